// ==== design/bridge_pkg.sv ====
// Bridge package: shared widths, I2C window base, timeout default and the enums

package bridge_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	// AXI4-Lite address and data widths, defaults for the top parameters
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// I2C register address is the lower half of the AXI address
	localparam int I2C_ADDR_W = 16;
	// One data byte per I2C transfer
	localparam int I2C_DATA_W = 8;

	//////////////////////////////////////////////////////////////////////
	// Address window and timeout
	//////////////////////////////////////////////////////////////////////

	// Upper address half must match this to reach the I2C side
	localparam logic [I2C_ADDR_W-1:0] I2C_BASE = 16'h1234;

	// Cycles to wait for the I2C acknowledge before giving up
	localparam int TIMEOUT_DEFAULT = 64;

	//////////////////////////////////////////////////////////////////////
	// Enums
	//////////////////////////////////////////////////////////////////////

	// AXI response codes, EXOKAY kept only for the encoding
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_t;

	// Operation sent along with the I2C request
	typedef enum logic {
		I2C_WRITE = 1'b0,
		I2C_READ  = 1'b1
	} i2c_op_t;

	// Transaction FSM states
	typedef enum logic [2:0] {
		IDLE, ACCEPT_WR, ACCEPT_RD, DECODE, WAIT_ACK, RESP_WR, RESP_RD
	} bridge_state_t;

endpackage

// ==== design/bridge_fsm.sv ====
// Transaction FSM: AXI4-Lite handshakes, outcome choice and the B/R response registers

module bridge_fsm
	import bridge_pkg::*;
(
	input  logic      ACLK,
	input  logic      SYN_RESET,
	// AXI handshake inputs
	input  logic      awvalid,
	input  logic      wvalid,
	input  logic      arvalid,
	input  logic      bready,
	input  logic      rready,
	// AXI handshake outputs
	output logic      awready,
	output logic      wready,
	output logic      arready,
	output logic      bvalid,
	output logic      rvalid,
	output axi_resp_t bresp,
	output axi_resp_t rresp,
	// Request path control
	output logic      capture_write,
	output logic      capture_read,
	output logic      issue,
	output logic      load_rdata,
	input  logic      addr_hit,
	// Acknowledge and timeout
	input  logic      ack_pulse,
	input  logic      expired,
	output logic      timer_run
);

	bridge_state_t state;
	bridge_state_t state_next;
	// High while the transaction in flight is a write
	logic          is_write;
	// Outcome picked in the cycle that leaves DECODE or WAIT_ACK
	axi_resp_t     resp_sel;

	//////////////////////////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
			begin
				// Write wins when both arrive together
				if (awvalid && wvalid)
					state_next = ACCEPT_WR;
				else if (arvalid)
					state_next = ACCEPT_RD;
			end
			ACCEPT_WR, ACCEPT_RD:
				state_next = DECODE;
			DECODE:
			begin
				if (addr_hit)
					state_next = WAIT_ACK;
				else
					state_next = is_write ? RESP_WR : RESP_RD;
			end
			WAIT_ACK:
			begin
				if (ack_pulse || expired)
					state_next = is_write ? RESP_WR : RESP_RD;
			end
			RESP_WR:
			begin
				if (bready)
					state_next = IDLE;
			end
			RESP_RD:
			begin
				if (rready)
					state_next = IDLE;
			end
			default:
				state_next = IDLE;
		endcase
	end

	// Miss gives DECERR, acknowledge beats a timeout in the same cycle
	always_comb
	begin
		resp_sel = OKAY;
		if (state == DECODE && !addr_hit)
			resp_sel = DECERR;
		else if (state == WAIT_ACK && !ack_pulse)
			resp_sel = SLVERR;
	end

	// Strobes to the request path
	assign capture_write = (state == ACCEPT_WR);
	assign capture_read  = (state == ACCEPT_RD);
	assign issue         = (state == DECODE) && addr_hit;
	assign load_rdata    = (state == WAIT_ACK) && ack_pulse && !is_write;

	//////////////////////////////////////////////////////////////////////
	// State and registered outputs
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
		begin
			state     <= IDLE;
			is_write  <= 1'b0;
			awready   <= 1'b0;
			wready    <= 1'b0;
			arready   <= 1'b0;
			bvalid    <= 1'b0;
			rvalid    <= 1'b0;
			bresp     <= OKAY;
			rresp     <= OKAY;
			timer_run <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (state_next == ACCEPT_WR)
				is_write <= 1'b1;
			else if (state_next == ACCEPT_RD)
				is_write <= 1'b0;
			// Ready pulses for the single accept cycle
			awready <= (state_next == ACCEPT_WR);
			wready  <= (state_next == ACCEPT_WR);
			arready <= (state_next == ACCEPT_RD);
			// Valid held until the master takes the response
			bvalid  <= (state_next == RESP_WR);
			rvalid  <= (state_next == RESP_RD);
			// Response loaded once on entry, then held stable
			if (state_next == RESP_WR && state != RESP_WR)
				bresp <= resp_sel;
			if (state_next == RESP_RD && state != RESP_RD)
				rresp <= resp_sel;
			// Timer runs from the second cycle of the wait
			timer_run <= (state == WAIT_ACK) && (state_next == WAIT_ACK);
		end
	end

endmodule

// ==== design/ack_timer.sv ====
// Acknowledge timer: counts the wait for the I2C side and flags expiry

module ack_timer
	import bridge_pkg::*;
#(
	parameter int TIMEOUT_CYCLES = TIMEOUT_DEFAULT
)
(
	input  logic ACLK,
	input  logic SYN_RESET,
	input  logic timer_run,
	output logic expired
);

	// Wide enough to hold TIMEOUT_CYCLES-1
	localparam int CNT_W = (TIMEOUT_CYCLES > 1) ? $clog2(TIMEOUT_CYCLES) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(TIMEOUT_CYCLES - 1);

	logic [CNT_W-1:0] count;

	// Cleared whenever the FSM is not waiting
	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
			count <= '0;
		else if (!timer_run)
			count <= '0;
		else if (count != LAST)
			count <= count + 1'b1;
	end

	// Terminal count while still running
	assign expired = timer_run && (count == LAST);

endmodule

// ==== design/ack_sync.sv ====
// Acknowledge synchronizer: brings the I2C ack toggle across and turns each change into a pulse

module ack_sync
(
	input  logic ACLK,
	input  logic SYN_RESET,
	input  logic i2c_ack,
	output logic ack_pulse
);

	// Two stages against metastability
	logic sync_1;
	logic sync_2;
	// Last settled level of the toggle
	logic ack_hist;

	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
		begin
			sync_1    <= 1'b0;
			sync_2    <= 1'b0;
			ack_hist  <= 1'b0;
			ack_pulse <= 1'b0;
		end
		else
		begin
			sync_1   <= i2c_ack;
			sync_2   <= sync_1;
			ack_hist <= sync_2;
			// Either edge of the toggle is one acknowledge
			ack_pulse <= sync_2 ^ ack_hist;
		end
	end

endmodule

// ==== design/request_path.sv ====
// Request path: address and data capture, window decode, I2C request toggle and read data

module request_path
	import bridge_pkg::*;
#(
	parameter int ADDR_W = bridge_pkg::ADDR_W,
	parameter int DATA_W = bridge_pkg::DATA_W
)
(
	input  logic                             ACLK,
	input  logic                             SYN_RESET,
	// AXI payload
	input  logic [ADDR_W-1:0]                awaddr,
	input  logic [DATA_W-1:0]                wdata,
	input  logic [ADDR_W-1:0]                araddr,
	// Read byte from the I2C side
	input  logic [I2C_DATA_W-1:0]            i2c_rdata,
	// FSM strobes
	input  logic                             capture_write,
	input  logic                             capture_read,
	input  logic                             issue,
	input  logic                             load_rdata,
	output logic                             addr_hit,
	// I2C request
	output logic                             i2c_req,
	output i2c_op_t                          i2c_op,
	output logic [I2C_ADDR_W+I2C_DATA_W-1:0] i2c_word,
	// AXI read data
	output logic [DATA_W-1:0]                rdata
);

	logic [ADDR_W-1:0]     addr_q;
	logic [I2C_DATA_W-1:0] wbyte_q;
	i2c_op_t               op_q;

	//////////////////////////////////////////////////////////////////////
	// Capture
	//////////////////////////////////////////////////////////////////////

	// Address and data byte of the accepted transaction
	always_ff @(posedge ACLK)
	begin
		if (capture_write)
		begin
			addr_q  <= awaddr;
			wbyte_q <= wdata[I2C_DATA_W-1:0];
		end
		else if (capture_read)
		begin
			addr_q  <= araddr;
			// Reads carry a zero data byte
			wbyte_q <= '0;
		end
	end

	// Operation of the transaction in flight
	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
			op_q <= I2C_WRITE;
		else if (capture_write)
			op_q <= I2C_WRITE;
		else if (capture_read)
			op_q <= I2C_READ;
	end

	// Window check on the upper address half
	assign addr_hit = (addr_q[ADDR_W-1 -: I2C_ADDR_W] == I2C_BASE);

	//////////////////////////////////////////////////////////////////////
	// I2C request
	//////////////////////////////////////////////////////////////////////

	// Word and op change with the toggle, then stay put until the next issue
	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
		begin
			i2c_req  <= 1'b0;
			i2c_op   <= I2C_WRITE;
			i2c_word <= '0;
		end
		else if (issue)
		begin
			i2c_req  <= ~i2c_req;
			i2c_op   <= op_q;
			// Register address first, data byte last
			i2c_word <= {addr_q[I2C_ADDR_W-1:0], wbyte_q};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read data
	//////////////////////////////////////////////////////////////////////

	// Zero unless an acknowledged read loads the byte
	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
			rdata <= '0;
		else if (capture_write || capture_read)
			rdata <= '0;
		else if (load_rdata)
			rdata <= DATA_W'(i2c_rdata);
	end

endmodule

// ==== design/i2c_bridge_top.sv ====
// AXI4-Lite to I2C bridge top: FSM, ack timer, ack synchronizer and request path

module i2c_bridge_top
	import bridge_pkg::*;
#(
	parameter int ADDR_W         = bridge_pkg::ADDR_W,
	parameter int DATA_W         = bridge_pkg::DATA_W,
	parameter int TIMEOUT_CYCLES = TIMEOUT_DEFAULT
)
(
	input  logic                             ACLK,
	input  logic                             SYN_RESET,
	// Write address and data
	input  logic                             awvalid,
	output logic                             awready,
	input  logic [ADDR_W-1:0]                awaddr,
	input  logic                             wvalid,
	output logic                             wready,
	input  logic [DATA_W-1:0]                wdata,
	// Write response
	output logic                             bvalid,
	input  logic                             bready,
	output axi_resp_t                        bresp,
	// Read address
	input  logic                             arvalid,
	output logic                             arready,
	input  logic [ADDR_W-1:0]                araddr,
	// Read data
	output logic                             rvalid,
	input  logic                             rready,
	output logic [DATA_W-1:0]                rdata,
	output axi_resp_t                        rresp,
	// I2C master side
	output logic                             i2c_req,
	output i2c_op_t                          i2c_op,
	output logic [I2C_ADDR_W+I2C_DATA_W-1:0] i2c_word,
	input  logic                             i2c_ack,
	input  logic [I2C_DATA_W-1:0]            i2c_rdata
);

	// FSM to request path
	logic capture_write;
	logic capture_read;
	logic issue;
	logic load_rdata;
	logic addr_hit;
	// Wait for the acknowledge
	logic timer_run;
	logic expired;
	logic ack_pulse;

	bridge_fsm u_fsm (
		.ACLK          (ACLK),
		.SYN_RESET     (SYN_RESET),
		.awvalid       (awvalid),
		.wvalid        (wvalid),
		.arvalid       (arvalid),
		.bready        (bready),
		.rready        (rready),
		.awready       (awready),
		.wready        (wready),
		.arready       (arready),
		.bvalid        (bvalid),
		.rvalid        (rvalid),
		.bresp         (bresp),
		.rresp         (rresp),
		.capture_write (capture_write),
		.capture_read  (capture_read),
		.issue         (issue),
		.load_rdata    (load_rdata),
		.addr_hit      (addr_hit),
		.ack_pulse     (ack_pulse),
		.expired       (expired),
		.timer_run     (timer_run)
	);

	ack_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_timer (
		.ACLK      (ACLK),
		.SYN_RESET (SYN_RESET),
		.timer_run (timer_run),
		.expired   (expired)
	);

	// Acknowledge toggle from the I2C clock domain
	ack_sync u_sync (
		.ACLK      (ACLK),
		.SYN_RESET (SYN_RESET),
		.i2c_ack   (i2c_ack),
		.ack_pulse (ack_pulse)
	);

	request_path #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_req (
		.ACLK          (ACLK),
		.SYN_RESET     (SYN_RESET),
		.awaddr        (awaddr),
		.wdata         (wdata),
		.araddr        (araddr),
		.i2c_rdata     (i2c_rdata),
		.capture_write (capture_write),
		.capture_read  (capture_read),
		.issue         (issue),
		.load_rdata    (load_rdata),
		.addr_hit      (addr_hit),
		.i2c_req       (i2c_req),
		.i2c_op        (i2c_op),
		.i2c_word      (i2c_word),
		.rdata         (rdata)
	);

endmodule

// ==== bench/bridge_cases.svh ====
// Bridge test table: one AXI transaction per row with its I2C responder behavior

// Columns: name, write (1) or read (0), AXI address, write data,
// silent responder (1) or acknowledging (0), byte the responder returns
localparam int NUM_CASES = 8;

localparam string CASE_NAME [NUM_CASES] = '{
	"wr_hit", "rd_hit", "wr_miss", "rd_miss",
	"wr_silent", "rd_silent", "rd_after_silent", "wr_hit_top"
};

localparam bit CASE_WRITE [NUM_CASES] = '{1, 0, 1, 0, 1, 0, 0, 1};

// Upper half 16'h1234 is inside the window
localparam logic [31:0] CASE_ADDR [NUM_CASES] = '{
	32'h1234_0010, 32'h1234_0011, 32'h4321_0020, 32'h1235_0021,
	32'h1234_0030, 32'h1234_0031, 32'h1234_fffe, 32'h1234_8001
};

// Only the low byte reaches the I2C word
localparam logic [31:0] CASE_WDATA [NUM_CASES] = '{
	32'h0000_00a5, 32'h0000_0000, 32'h0000_0077, 32'h0000_0000,
	32'hdead_be5a, 32'h0000_0000, 32'h0000_0000, 32'h1234_5681
};

localparam bit CASE_SILENT [NUM_CASES] = '{0, 0, 0, 0, 1, 1, 0, 0};

localparam logic [7:0] CASE_RBYTE [NUM_CASES] = '{
	8'h00, 8'h3c, 8'h00, 8'hff, 8'h00, 8'h99, 8'hc3, 8'h00
};

// ==== bench/bridge_checker.sv ====
// Bridge monitor: predicts I2C requests and AXI responses from the test table and compares them

module bridge_checker
	import bridge_pkg::*;
(
	input  logic        ACLK,
	input  logic        SYN_RESET,
	input  logic        awvalid,
	input  logic        arvalid,
	input  logic        awready,
	input  logic        wready,
	input  logic        arready,
	input  logic        bvalid,
	input  logic        bready,
	input  axi_resp_t   bresp,
	input  logic        rvalid,
	input  logic        rready,
	input  axi_resp_t   rresp,
	input  logic [31:0] rdata,
	input  logic        i2c_req,
	input  i2c_op_t     i2c_op,
	input  logic [23:0] i2c_word,
	output int          mismatch_count,
	output int          rows_done
);

	timeunit 1ns;
	timeprecision 1ps;

	`include "bridge_cases.svh"

	// Requests seen for the row in flight
	int        req_changes;
	logic      req_prev;
	logic      seen_valid;
	// Response was stalled on the previous edge
	logic      bwait;
	logic      rwait;
	axi_resp_t held_bresp;
	axi_resp_t held_rresp;
	logic [31:0] held_rdata;

	initial
	begin
		mismatch_count = 0;
		rows_done      = 0;
	end

	//////////////////////////////////////////////////////////////////////
	// Prediction
	//////////////////////////////////////////////////////////////////////

	function automatic bit in_window(logic [31:0] addr);
		return addr[31:16] == I2C_BASE;
	endfunction

	// Miss, then silent side, then a normal acknowledge
	function automatic axi_resp_t expected_resp(int idx);
		if (!in_window(CASE_ADDR[idx]))
			return DECERR;
		return CASE_SILENT[idx] ? SLVERR : OKAY;
	endfunction

	// Register address first, zero byte on reads
	function automatic logic [23:0] expected_word(int idx);
		return {CASE_ADDR[idx][15:0], CASE_WRITE[idx] ? CASE_WDATA[idx][7:0] : 8'h00};
	endfunction

	function automatic logic [31:0] expected_rdata(int idx);
		if (in_window(CASE_ADDR[idx]) && !CASE_SILENT[idx])
			return {24'h0, CASE_RBYTE[idx]};
		return 32'h0;
	endfunction

	function automatic string row_name();
		return (rows_done < NUM_CASES) ? CASE_NAME[rows_done] : "beyond_table";
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Comparison
	//////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(string test, string field, logic [31:0] expected,
		logic [31:0] actual);
		$display("FAILED %s %s: expected %h, actual %h", test, field, expected, actual);
		mismatch_count++;
	endtask

	// Outputs that must stay quiet in and right after reset
	task automatic check_idle(string test);
		if (awready)
			report_mismatch(test, "awready", 0, awready);
		if (wready)
			report_mismatch(test, "wready", 0, wready);
		if (arready)
			report_mismatch(test, "arready", 0, arready);
		if (bvalid)
			report_mismatch(test, "bvalid", 0, bvalid);
		if (rvalid)
			report_mismatch(test, "rvalid", 0, rvalid);
		if (i2c_req)
			report_mismatch(test, "i2c_req", 0, i2c_req);
	endtask

	task automatic check_request(int idx);
		i2c_op_t op_exp;
		op_exp = CASE_WRITE[idx] ? I2C_WRITE : I2C_READ;
		if (i2c_op != op_exp)
			report_mismatch(CASE_NAME[idx], "i2c_op", 32'(op_exp), 32'(i2c_op));
		if (i2c_word != expected_word(idx))
			report_mismatch(CASE_NAME[idx], "i2c_word", 32'(expected_word(idx)), 32'(i2c_word));
	endtask

	task automatic check_response(bit is_write);
		int    idx;
		string name;
		idx = rows_done;
		if (idx >= NUM_CASES)
		begin
			$display("Response arrived after the last table row");
			mismatch_count++;
		end
		else
		begin
			name = CASE_NAME[idx];
			if (CASE_WRITE[idx] != is_write)
				report_mismatch(name, "channel", CASE_WRITE[idx], is_write);
			else if (is_write && bresp != expected_resp(idx))
				report_mismatch(name, "bresp", 32'(expected_resp(idx)), 32'(bresp));
			else if (!is_write)
			begin
				if (rresp != expected_resp(idx))
					report_mismatch(name, "rresp", 32'(expected_resp(idx)), 32'(rresp));
				if (rdata != expected_rdata(idx))
					report_mismatch(name, "rdata", expected_rdata(idx), rdata);
			end
			// One request for a hit, none for a miss
			if (req_changes != (in_window(CASE_ADDR[idx]) ? 1 : 0))
				report_mismatch(name, "requests", in_window(CASE_ADDR[idx]), req_changes);
			rows_done++;
		end
		req_changes = 0;
	endtask

	always @(posedge ACLK)
	begin
		if (!SYN_RESET)
		begin
			check_idle("reset");
			seen_valid  = 1'b0;
			req_prev    = 1'b0;
			req_changes = 0;
			bwait       = 1'b0;
			rwait       = 1'b0;
		end
		else
		begin
			if (!seen_valid)
				check_idle("after_reset");
			if (awvalid || arvalid)
				seen_valid = 1'b1;
			// Any level change is a new I2C request
			if (i2c_req != req_prev)
			begin
				req_changes++;
				if (rows_done < NUM_CASES)
					check_request(rows_done);
			end
			req_prev = i2c_req;
			// Stalled response must hold
			if (bwait && !bvalid)
				report_mismatch(row_name(), "held bvalid", 1, bvalid);
			if (bwait && bresp != held_bresp)
				report_mismatch(row_name(), "held bresp", 32'(held_bresp), 32'(bresp));
			if (rwait && !rvalid)
				report_mismatch(row_name(), "held rvalid", 1, rvalid);
			if (rwait && rresp != held_rresp)
				report_mismatch(row_name(), "held rresp", 32'(held_rresp), 32'(rresp));
			if (rwait && rdata != held_rdata)
				report_mismatch(row_name(), "held rdata", held_rdata, rdata);
			// No new address while a response is pending
			if ((bvalid || rvalid) && (awready || arready))
				report_mismatch(row_name(), "ready during response", 0, 1);
			if (bvalid && bready)
				check_response(1'b1);
			if (rvalid && rready)
				check_response(1'b0);
			bwait      = bvalid && !bready;
			rwait      = rvalid && !rready;
			held_bresp = bresp;
			held_rresp = rresp;
			held_rdata = rdata;
		end
	end

endmodule

// ==== bench/bridge_tb.sv ====
// Bridge testbench: clock, reset, table-driven AXI4-Lite master and I2C responder model

module bridge_tb
	import bridge_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	`include "bridge_cases.svh"

	// Longer than the ack timeout plus the synchronizer
	localparam int WAIT_LIMIT = 200;

	logic        ACLK;
	logic        SYN_RESET;
	logic        awvalid;
	logic        awready;
	logic [31:0] awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic        bvalid;
	logic        bready;
	axi_resp_t   bresp;
	logic        arvalid;
	logic        arready;
	logic [31:0] araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	axi_resp_t   rresp;
	logic        i2c_req;
	i2c_op_t     i2c_op;
	logic [23:0] i2c_word;
	logic        i2c_ack;
	logic [7:0]  i2c_rdata;

	int   row;
	int   timeout_count;
	bit   abort;
	int   mismatch_count;
	int   rows_done;
	int   total_errors;
	// Responder state
	logic req_seen;
	int   ack_delay;
	int   resp_wait;

	i2c_bridge_top #(.TIMEOUT_CYCLES(TIMEOUT_DEFAULT)) uut (.*);

	bridge_checker u_checker (.*);

	always #2 ACLK = ~ACLK;

	//////////////////////////////////////////////////////////////////////
	// AXI master
	//////////////////////////////////////////////////////////////////////

	// Present the address, and data for writes, until the DUT takes it
	task automatic drive_address(int idx);
		int waited;
		bit accepted;
		waited   = 0;
		accepted = 1'b0;
		@(posedge ACLK);
		if (CASE_WRITE[idx])
		begin
			awvalid <= 1'b1;
			awaddr  <= CASE_ADDR[idx];
			wvalid  <= 1'b1;
			wdata   <= CASE_WDATA[idx];
		end
		else
		begin
			arvalid <= 1'b1;
			araddr  <= CASE_ADDR[idx];
		end
		while (!accepted && waited < WAIT_LIMIT)
		begin
			@(posedge ACLK);
			waited++;
			accepted = CASE_WRITE[idx] ? (awready && wready) : arready;
		end
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		arvalid <= 1'b0;
		if (!accepted)
		begin
			$display("Timeout: %s address was never accepted", CASE_NAME[idx]);
			timeout_count++;
			abort = 1'b1;
		end
	endtask

	// Wait for the response, stall it a random number of cycles, then take it
	task automatic take_response(int idx);
		int waited;
		int stall;
		bit seen;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < WAIT_LIMIT)
		begin
			@(posedge ACLK);
			waited++;
			seen = CASE_WRITE[idx] ? bvalid : rvalid;
		end
		if (!seen)
		begin
			$display("Timeout: %s got no response", CASE_NAME[idx]);
			timeout_count++;
			abort = 1'b1;
			return;
		end
		stall = $urandom % 5;
		repeat (stall) @(posedge ACLK);
		bready <= CASE_WRITE[idx];
		rready <= !CASE_WRITE[idx];
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < WAIT_LIMIT)
		begin
			@(posedge ACLK);
			waited++;
			seen = CASE_WRITE[idx] ? (bvalid && bready) : (rvalid && rready);
		end
		bready <= 1'b0;
		rready <= 1'b0;
		if (!seen)
		begin
			$display("Timeout: %s response was withdrawn before it was taken", CASE_NAME[idx]);
			timeout_count++;
			abort = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// I2C responder
	//////////////////////////////////////////////////////////////////////

	// Silent rows answer only once the bridge has already responded
	always
	begin
		@(posedge ACLK);
		if (SYN_RESET && i2c_req != req_seen && row < NUM_CASES)
		begin
			req_seen = i2c_req;
			// Read byte settles before the toggle
			// A silent row still offers one, which must never reach rdata
			i2c_rdata <= CASE_RBYTE[row];
			if (!CASE_SILENT[row])
			begin
				ack_delay = 1 + ($urandom % 12);
				repeat (ack_delay) @(posedge ACLK);
				i2c_ack <= ~i2c_ack;
			end
			else
			begin
				resp_wait = 0;
				while (!(bvalid || rvalid) && resp_wait < WAIT_LIMIT)
				begin
					@(posedge ACLK);
					resp_wait++;
				end
				if (!(bvalid || rvalid))
				begin
					$display("Timeout: no response for silent row %s", CASE_NAME[row]);
					timeout_count++;
				end
				i2c_ack <= ~i2c_ack;
			end
		end
	end

	initial
	begin
		void'($urandom(32'h752a_c967));
		ACLK          = 1'b0;
		SYN_RESET     = 1'b0;
		awvalid       = 1'b0;
		awaddr        = '0;
		wvalid        = 1'b0;
		wdata         = '0;
		bready        = 1'b0;
		arvalid       = 1'b0;
		araddr        = '0;
		rready        = 1'b0;
		i2c_ack       = 1'b0;
		i2c_rdata     = '0;
		req_seen      = 1'b0;
		row           = 0;
		timeout_count = 0;
		abort         = 1'b0;
		repeat (8) @(posedge ACLK);
		SYN_RESET <= 1'b1;
		repeat (3) @(posedge ACLK);
		// Idle gap lets a late acknowledge drain before the next request
		for (row = 0; row < NUM_CASES && !abort; row++)
		begin
			drive_address(row);
			if (!abort)
				take_response(row);
			repeat (4) @(posedge ACLK);
		end
		repeat (4) @(posedge ACLK);
		total_errors = mismatch_count + timeout_count;
		if (rows_done != NUM_CASES)
		begin
			$display("Only %0d of %0d table rows got a checked response", rows_done, NUM_CASES);
			total_errors++;
		end
		$display("Summary: %0d mismatches, %0d timeouts, %0d of %0d rows checked",
			mismatch_count, timeout_count, rows_done, NUM_CASES);
		if (total_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+bench
design/bridge_pkg.sv
design/bridge_fsm.sv
design/ack_timer.sv
design/ack_sync.sv
design/request_path.sv
design/i2c_bridge_top.sv
bench/bridge_checker.sv
bench/bridge_tb.sv
